// File: rtl/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

  localparam int NUM_TAGS     = 32;  // Physical tags
  localparam int TAG_W        = 5;   // log2(NUM_TAGS)
  localparam int DATA_W       = 16;  // Datapath width
  localparam int RS_ALU_DEPTH = 4;   // ALU RS slots
  localparam int RS_MUL_DEPTH = 2;   // MUL RS slots
  localparam int MUL_LAT      = 3;   // Multiplier stages

  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [DATA_W-1:0] data_t;

  typedef enum logic {ALU, MUL} fu_class_e;

  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_XOR = 3'd3,
    OP_MUL = 3'd4
  } opcode_e;

  typedef struct packed {
    tag_t tag;   // Producer tag
    logic rdy;   // Value available
  } src_t;

  typedef struct packed {
    logic    busy;
    opcode_e op;
    tag_t    dest;
    src_t    src1;
    src_t    src2;
  } rs_entry_t;

  typedef struct packed {
    opcode_e op;
    tag_t    dest;
    data_t   a;     // Operand 1 value
    data_t   b;     // Operand 2 value
  } fu_req_t;

  typedef struct packed {
    tag_t  tag;
    data_t value;
  } cdb_t;

  // Only MUL goes to the multiplier
  function automatic fu_class_e op_class(opcode_e op);
    return (op == OP_MUL) ? MUL : ALU;
  endfunction

endpackage

`default_nettype wire

// File: rtl/ooo_if.sv
`timescale 1ns/1ps
`default_nettype none

// RS to one execution unit
interface issue_if;
  import ooo_pkg::*;

  logic    valid;
  logic    ready;      // Unit can take an op
  opcode_e op;
  tag_t    dest;
  tag_t    src1_tag;   // Register file read address
  tag_t    src2_tag;
  data_t   src1_val;   // Register file read data
  data_t   src2_val;
  fu_req_t req;

  assign req = '{op: op, dest: dest, a: src1_val, b: src2_val};  // Bundle for the unit

  modport source (output valid, op, dest, src1_tag, src2_tag, input ready);
  modport sink   (input valid, req, output ready);
endinterface

// Common data bus, one result per cycle
interface cdb_if;
  import ooo_pkg::*;

  logic  valid;
  tag_t  tag;
  data_t value;

  modport driver  (output valid, tag, value);
  modport monitor (input valid, tag, value);
endinterface

`default_nettype wire

// File: rtl/dispatch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_stage (
  input  logic               clock,
  input  logic               reset,
  input  logic               in_valid,
  output logic               in_ready,
  input  ooo_pkg::opcode_e   in_op,
  input  ooo_pkg::tag_t      in_dest,
  input  ooo_pkg::tag_t      in_src1,
  input  ooo_pkg::tag_t      in_src2,
  output ooo_pkg::tag_t      rd_tag1,
  output ooo_pkg::tag_t      rd_tag2,
  input  logic               src1_rdy,
  input  logic               src2_rdy,
  output logic               busy_set_valid,
  output ooo_pkg::tag_t      busy_set_tag,
  cdb_if.monitor             cdb,
  output logic               ds_valid,
  input  logic               ds_ready,
  output ooo_pkg::rs_entry_t ds_entry
);
  import ooo_pkg::*;

  rs_entry_t           entry_q;  // Held instruction
  logic                full_q;
  logic                accept;   // Input handshake
  logic                take;     // RS handshake
  logic [NUM_TAGS-1:0] busy_q;   // Shadow of outstanding dests

  function automatic logic cdb_hit(tag_t t);
    return cdb.valid && (cdb.tag == t);
  endfunction

  assign ds_valid       = full_q;
  assign take           = full_q && ds_ready;
  assign in_ready       = !full_q || ds_ready;  // Empty or draining
  assign accept         = in_valid && in_ready;
  assign rd_tag1        = in_src1;              // Ready lookup
  assign rd_tag2        = in_src2;
  assign busy_set_valid = accept;
  assign busy_set_tag   = in_dest;

  // Forward with same-cycle wakeup folded in
  always_comb begin
    ds_entry          = entry_q;
    ds_entry.src1.rdy = entry_q.src1.rdy || cdb_hit(entry_q.src1.tag);
    ds_entry.src2.rdy = entry_q.src2.rdy || cdb_hit(entry_q.src2.tag);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      full_q <= 1'b0;
    end else if (accept) begin
      full_q <= 1'b1;
    end else if (take) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      entry_q.busy     <= 1'b1;
      entry_q.op       <= in_op;
      entry_q.dest     <= in_dest;
      entry_q.src1.tag <= in_src1;
      entry_q.src1.rdy <= src1_rdy || cdb_hit(in_src1);  // Completing now counts
      entry_q.src2.tag <= in_src2;
      entry_q.src2.rdy <= src2_rdy || cdb_hit(in_src2);
    end else begin
      entry_q.src1.rdy <= ds_entry.src1.rdy;  // Keep snooping while stalled
      entry_q.src2.rdy <= ds_entry.src2.rdy;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy_q <= '0;
    end else begin
      if (accept) begin
        busy_q[in_dest] <= 1'b1;
      end
      if (cdb.valid) begin
        busy_q[cdb.tag] <= 1'b0;
      end
    end
  end

  // A tag is reused only after its previous result was broadcast
  a_dest_free : assert property (@(posedge clock) disable iff (reset)
    accept |-> !busy_q[in_dest])
    else $error("dispatch of busy destination tag %0d", in_dest);

endmodule

`default_nettype wire

// File: rtl/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

module reservation_station (
  input  logic               clock,
  input  logic               reset,
  input  logic               ds_valid,
  output logic               ds_ready,
  input  ooo_pkg::rs_entry_t ds_entry,
  cdb_if.monitor             cdb,
  issue_if.source            alu_iss,
  issue_if.source            mul_iss
);
  import ooo_pkg::*;

  localparam int N_ENT = RS_ALU_DEPTH + RS_MUL_DEPTH;  // ALU slots first, then MUL
  localparam int IDX_W = $clog2(N_ENT);

  rs_entry_t        ent_q [N_ENT];
  logic [N_ENT-1:0] s1_rdy;      // Ready incl. this cycle's bus
  logic [N_ENT-1:0] s2_rdy;
  logic [N_ENT-1:0] can_issue;
  logic [N_ENT-1:0] leave;       // Issued this cycle
  logic [N_ENT-1:0] is_free;
  logic             alu_found;
  logic             mul_found;
  logic             alloc_found;
  logic [IDX_W-1:0] alu_idx;
  logic [IDX_W-1:0] mul_idx;
  logic [IDX_W-1:0] alloc_idx;
  fu_class_e        in_class;
  logic             dup_dest;
  logic             early_issue;  // Issued while its producer still waits here

  function automatic fu_class_e slot_class(int i);
    return (i < RS_ALU_DEPTH) ? ALU : MUL;
  endfunction

  // Wakeup and lowest-index issue select per class
  always_comb begin
    alu_found = 1'b0;
    mul_found = 1'b0;
    alu_idx   = '0;
    mul_idx   = '0;
    for (int i = 0; i < N_ENT; i++) begin
      s1_rdy[i]    = ent_q[i].src1.rdy || (cdb.valid && cdb.tag == ent_q[i].src1.tag);
      s2_rdy[i]    = ent_q[i].src2.rdy || (cdb.valid && cdb.tag == ent_q[i].src2.tag);
      can_issue[i] = ent_q[i].busy && s1_rdy[i] && s2_rdy[i];
      if (can_issue[i] && slot_class(i) == ALU && !alu_found) begin
        alu_found = 1'b1;
        alu_idx   = IDX_W'(i);
      end
      if (can_issue[i] && slot_class(i) == MUL && !mul_found) begin
        mul_found = 1'b1;
        mul_idx   = IDX_W'(i);
      end
    end
  end

  assign alu_iss.valid    = alu_found;
  assign alu_iss.op       = ent_q[alu_idx].op;
  assign alu_iss.dest     = ent_q[alu_idx].dest;
  assign alu_iss.src1_tag = ent_q[alu_idx].src1.tag;  // Values read at issue
  assign alu_iss.src2_tag = ent_q[alu_idx].src2.tag;
  assign mul_iss.valid    = mul_found;
  assign mul_iss.op       = ent_q[mul_idx].op;
  assign mul_iss.dest     = ent_q[mul_idx].dest;
  assign mul_iss.src1_tag = ent_q[mul_idx].src1.tag;
  assign mul_iss.src2_tag = ent_q[mul_idx].src2.tag;

  // Lowest free slot of the class, slots leaving now included
  always_comb begin
    in_class    = op_class(ds_entry.op);
    alloc_found = 1'b0;
    alloc_idx   = '0;
    for (int i = 0; i < N_ENT; i++) begin
      leave[i]   = (alu_found && alu_iss.ready && alu_idx == IDX_W'(i)) ||
                   (mul_found && mul_iss.ready && mul_idx == IDX_W'(i));
      is_free[i] = !ent_q[i].busy || leave[i];
      if (is_free[i] && slot_class(i) == in_class && !alloc_found) begin
        alloc_found = 1'b1;
        alloc_idx   = IDX_W'(i);
      end
    end
  end

  assign ds_ready = alloc_found;

  always_ff @(posedge clock) begin
    for (int i = 0; i < N_ENT; i++) begin
      if (reset) begin
        ent_q[i].busy <= 1'b0;
      end else if (ds_valid && ds_ready && alloc_idx == IDX_W'(i)) begin
        ent_q[i] <= ds_entry;
      end else if (leave[i]) begin
        ent_q[i].busy <= 1'b0;
      end else begin
        ent_q[i].src1.rdy <= s1_rdy[i];  // Latch wakeup
        ent_q[i].src2.rdy <= s2_rdy[i];
      end
    end
  end

  always_comb begin
    dup_dest    = 1'b0;
    early_issue = 1'b0;
    for (int i = 0; i < N_ENT; i++) begin
      for (int j = i + 1; j < N_ENT; j++) begin
        if (ent_q[i].busy && ent_q[j].busy && ent_q[i].dest == ent_q[j].dest) begin
          dup_dest = 1'b1;
        end
      end
      for (int j = 0; j < N_ENT; j++) begin
        if (leave[i] && ent_q[j].busy && (ent_q[j].dest == ent_q[i].src1.tag ||
                                          ent_q[j].dest == ent_q[i].src2.tag)) begin
          early_issue = 1'b1;
        end
      end
    end
  end

  // A source whose producer still sits in the RS has no value yet
  a_issue_ready : assert property (@(posedge clock) disable iff (reset) !early_issue)
    else $error("RS issued an entry with a source not ready");

  // Holds across allocation history, not just one cycle
  a_unique_dest : assert property (@(posedge clock) disable iff (reset) !dup_dest)
    else $error("two busy RS entries share a destination tag");

endmodule

`default_nettype wire

// File: rtl/phys_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module phys_regfile (
  input  logic           clock,
  input  logic           reset,
  cdb_if.monitor         cdb,
  input  logic           busy_set_valid,
  input  ooo_pkg::tag_t  busy_set_tag,
  input  ooo_pkg::tag_t  rd_tag1,
  input  ooo_pkg::tag_t  rd_tag2,
  input  ooo_pkg::tag_t  alu_tag1,
  input  ooo_pkg::tag_t  alu_tag2,
  input  ooo_pkg::tag_t  mul_tag1,
  input  ooo_pkg::tag_t  mul_tag2,
  output logic           src1_rdy,
  output logic           src2_rdy,
  output ooo_pkg::data_t alu_val1,
  output ooo_pkg::data_t alu_val2,
  output ooo_pkg::data_t mul_val1,
  output ooo_pkg::data_t mul_val2
);
  import ooo_pkg::*;

  data_t               value_q [NUM_TAGS];
  logic [NUM_TAGS-1:0] ready_q;

  // Current broadcast bypasses the array
  function automatic data_t read_val(tag_t t);
    return (cdb.valid && cdb.tag == t) ? cdb.value : value_q[t];
  endfunction

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int t = 0; t < NUM_TAGS; t++) begin
        value_q[t] <= data_t'(t);  // Tag t starts at value t
        ready_q[t] <= 1'b1;
      end
    end else begin
      if (busy_set_valid) begin
        ready_q[busy_set_tag] <= 1'b0;
      end
      if (cdb.valid) begin        // Later assignment so the bus wins
        value_q[cdb.tag] <= cdb.value;
        ready_q[cdb.tag] <= 1'b1;
      end
    end
  end

  assign src1_rdy = ready_q[rd_tag1];  // Dispatch adds its own bus match
  assign src2_rdy = ready_q[rd_tag2];
  assign alu_val1 = read_val(alu_tag1);
  assign alu_val2 = read_val(alu_tag2);
  assign mul_val1 = read_val(mul_tag1);
  assign mul_val2 = read_val(mul_tag2);

endmodule

`default_nettype wire

// File: rtl/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit #(
  parameter ooo_pkg::fu_class_e FU_CLASS = ooo_pkg::ALU
) (
  input  logic         clock,
  input  logic         reset,
  issue_if.sink        iss,
  input  logic         grant,
  output logic         res_valid,
  output ooo_pkg::cdb_t res
);
  import ooo_pkg::*;

  if (FU_CLASS == ALU) begin : g_alu
    data_t alu_out;

    always_comb begin
      case (iss.req.op)
        OP_ADD:  alu_out = iss.req.a + iss.req.b;
        OP_SUB:  alu_out = iss.req.a - iss.req.b;
        OP_AND:  alu_out = iss.req.a & iss.req.b;
        OP_XOR:  alu_out = iss.req.a ^ iss.req.b;
        default: alu_out = iss.req.a + iss.req.b;  // MUL never routed here
      endcase
    end

    assign iss.ready = !res_valid || grant;  // Hold reg free or draining

    always_ff @(posedge clock) begin
      if (reset) begin
        res_valid <= 1'b0;
      end else if (iss.valid && iss.ready) begin
        res_valid <= 1'b1;
      end else if (grant) begin
        res_valid <= 1'b0;
      end
    end

    always_ff @(posedge clock) begin
      if (iss.valid && iss.ready) begin
        res <= '{tag: iss.req.dest, value: alu_out};
      end
    end
  end else begin : g_mul
    logic [MUL_LAT-1:0] v_q;            // Stage valids
    cdb_t               stage_q [MUL_LAT];
    logic               advance;

    assign advance   = !v_q[MUL_LAT-1] || grant;  // Whole pipe stalls otherwise
    assign iss.ready = advance;

    always_ff @(posedge clock) begin
      if (reset) begin
        v_q <= '0;
      end else if (advance) begin
        v_q <= {v_q[MUL_LAT-2:0], iss.valid};
      end
    end

    always_ff @(posedge clock) begin
      if (advance) begin
        stage_q[0] <= '{tag: iss.req.dest, value: data_t'(iss.req.a * iss.req.b)};  // Low bits
        for (int s = 1; s < MUL_LAT; s++) begin
          stage_q[s] <= stage_q[s-1];
        end
      end
    end

    assign res_valid = v_q[MUL_LAT-1];
    assign res       = stage_q[MUL_LAT-1];
  end

  a_res_hold : assert property (@(posedge clock) disable iff (reset)
    res_valid && !grant |=> res_valid && $stable(res))
    else $error("ungranted result changed or dropped");

endmodule

`default_nettype wire

// File: rtl/cdb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
  input  logic          alu_valid,
  input  ooo_pkg::cdb_t alu_res,
  input  logic          mul_valid,
  input  ooo_pkg::cdb_t mul_res,
  output logic          alu_grant,
  output logic          mul_grant,
  cdb_if.driver         cdb
);
  import ooo_pkg::*;

  cdb_t winner;

  assign mul_grant = mul_valid;                // MUL has priority
  assign alu_grant = alu_valid && !mul_valid;
  assign winner    = mul_valid ? mul_res : alu_res;

  assign cdb.valid = alu_valid || mul_valid;   // Never stalled
  assign cdb.tag   = winner.tag;
  assign cdb.value = winner.value;

endmodule

`default_nettype wire

// File: rtl/ooo_issue_top.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_issue_top (
  input  logic             clock,
  input  logic             reset,
  input  logic             in_valid,
  output logic             in_ready,
  input  ooo_pkg::opcode_e in_op,
  input  ooo_pkg::tag_t    in_dest,
  input  ooo_pkg::tag_t    in_src1,
  input  ooo_pkg::tag_t    in_src2,
  output logic             cmp_valid,
  output ooo_pkg::tag_t    cmp_tag,
  output ooo_pkg::data_t   cmp_value
);
  import ooo_pkg::*;

  tag_t      rd_tag1;
  tag_t      rd_tag2;
  logic      src1_rdy;
  logic      src2_rdy;
  logic      busy_set_valid;
  tag_t      busy_set_tag;
  logic      ds_valid;
  logic      ds_ready;
  rs_entry_t ds_entry;
  logic      alu_res_valid;
  logic      mul_res_valid;
  cdb_t      alu_res;
  cdb_t      mul_res;
  logic      alu_grant;
  logic      mul_grant;

  issue_if alu_iss ();
  issue_if mul_iss ();
  cdb_if   cdb_bus ();

  dispatch_stage u_dispatch (
    .clock, .reset, .in_valid, .in_ready, .in_op, .in_dest, .in_src1, .in_src2,
    .rd_tag1, .rd_tag2, .src1_rdy, .src2_rdy, .busy_set_valid, .busy_set_tag,
    .cdb (cdb_bus), .ds_valid, .ds_ready, .ds_entry
  );

  reservation_station u_rs (
    .clock, .reset, .ds_valid, .ds_ready, .ds_entry,
    .cdb (cdb_bus), .alu_iss (alu_iss), .mul_iss (mul_iss)
  );

  phys_regfile u_prf (
    .clock, .reset, .cdb (cdb_bus), .busy_set_valid, .busy_set_tag,
    .rd_tag1, .rd_tag2, .src1_rdy, .src2_rdy,
    .alu_tag1 (alu_iss.src1_tag), .alu_tag2 (alu_iss.src2_tag),
    .mul_tag1 (mul_iss.src1_tag), .mul_tag2 (mul_iss.src2_tag),
    .alu_val1 (alu_iss.src1_val), .alu_val2 (alu_iss.src2_val),
    .mul_val1 (mul_iss.src1_val), .mul_val2 (mul_iss.src2_val)
  );

  exec_unit #(.FU_CLASS(ALU)) u_alu (
    .clock, .reset, .iss (alu_iss), .grant (alu_grant), .res_valid (alu_res_valid),
    .res (alu_res)
  );

  exec_unit #(.FU_CLASS(MUL)) u_mul (
    .clock, .reset, .iss (mul_iss), .grant (mul_grant), .res_valid (mul_res_valid),
    .res (mul_res)
  );

  cdb_arbiter u_arb (
    .alu_valid (alu_res_valid), .alu_res, .mul_valid (mul_res_valid), .mul_res,
    .alu_grant, .mul_grant, .cdb (cdb_bus)
  );

  assign cmp_valid = cdb_bus.valid;  // Completion is the broadcast
  assign cmp_tag   = cdb_bus.tag;
  assign cmp_value = cdb_bus.value;

endmodule

`default_nettype wire

// File: dv/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  logic             clock,
  input  logic             reset,
  input  logic             in_valid,
  input  logic             in_ready,
  input  ooo_pkg::opcode_e in_op,
  input  ooo_pkg::tag_t    in_dest,
  input  ooo_pkg::tag_t    in_src1,
  input  ooo_pkg::tag_t    in_src2,
  input  logic             cmp_valid,
  input  ooo_pkg::tag_t    cmp_tag,
  input  ooo_pkg::data_t   cmp_value,
  output int               value_errs,
  output int               tag_errs,
  output int               order_errs,
  output int               pending
);
  import ooo_pkg::*;

  data_t               mirror    [NUM_TAGS];  // Value per tag after completion
  logic [NUM_TAGS-1:0] pend_valid;            // Dispatched, not yet completed
  opcode_e             pend_op   [NUM_TAGS];
  tag_t                pend_src1 [NUM_TAGS];
  tag_t                pend_src2 [NUM_TAGS];

  // Operation on two source values, wrapped to DATA_W bits
  function automatic data_t expected_value(opcode_e op, data_t a, data_t b);
    logic [2*DATA_W-1:0] prod;
    prod = a * b;
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_XOR:  return a ^ b;
      OP_MUL:  return prod[DATA_W-1:0];  // Low half of product
      default: return 'x;
    endcase
  endfunction

  initial begin
    for (int t = 0; t < NUM_TAGS; t++) begin
      mirror[t] = data_t'(t);  // Tag t holds t after reset
    end
    pend_valid = '0;
    value_errs = 0;
    tag_errs   = 0;
    order_errs = 0;
    pending    = 0;
  end

  // Sampled between the drive and the transferring rise
  always @(negedge clock) begin : watch
    data_t exp_val;
    if (!reset) begin
      if (cmp_valid) begin
        if (!pend_valid[cmp_tag]) begin
          $display("Unexpected or duplicate completion of tag %0d at %0t", cmp_tag, $time);
          tag_errs++;
        end else begin
          if (pend_valid[pend_src1[cmp_tag]] || pend_valid[pend_src2[cmp_tag]]) begin
            $display("Tag %0d completed before its producer at %0t", cmp_tag, $time);
            order_errs++;
          end
          exp_val = expected_value(pend_op[cmp_tag], mirror[pend_src1[cmp_tag]],
                                   mirror[pend_src2[cmp_tag]]);
          if (cmp_value !== exp_val) begin
            $display("FAIL %0t: tag %0d gave %h, expected %h", $time, cmp_tag,
                     cmp_value, exp_val);
            value_errs++;
          end
          mirror[cmp_tag]     = exp_val;  // Later consumers read the reference
          pend_valid[cmp_tag] = 1'b0;
          pending--;
        end
      end
      if (in_valid && in_ready) begin
        pend_valid[in_dest] = 1'b1;  // Queue op for out-of-order match
        pend_op[in_dest]    = in_op;
        pend_src1[in_dest]  = in_src1;
        pend_src2[in_dest]  = in_src2;
        pending++;
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;
  import ooo_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int RANDOM_INSTR = 300;
  localparam int TOTAL_INSTR  = 6 + 5 + 8 + 8 + RANDOM_INSTR;  // Directed plus random
  localparam int CYCLE_LIMIT  = TOTAL_INSTR * 40 + RESET_CYCLES;

  logic        clock;
  logic        reset;
  logic        in_valid;
  logic        in_ready;
  opcode_e     in_op;
  tag_t        in_dest;
  tag_t        in_src1;
  tag_t        in_src2;
  logic        cmp_valid;
  tag_t        cmp_tag;
  data_t       cmp_value;
  int          value_errs;
  int          tag_errs;
  int          order_errs;
  int          pending;
  int          stim_errs = 0;
  int          cycles = 0;
  int          sent;
  int          n;
  logic        saw_stall;    // in_ready seen low on a request
  tag_t        round_dests [$];

  ooo_issue_top u_dut (
    .clock, .reset, .in_valid, .in_ready, .in_op, .in_dest, .in_src1, .in_src2,
    .cmp_valid, .cmp_tag, .cmp_value
  );

  tb_checker u_checker (
    .clock, .reset, .in_valid, .in_ready, .in_op, .in_dest, .in_src1, .in_src2,
    .cmp_valid, .cmp_tag, .cmp_value, .value_errs, .tag_errs, .order_errs, .pending
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, %0d completions missing", cycles, pending);
      $display("Errors: value %0d, tag %0d, order %0d, stimulus %0d",
               value_errs, tag_errs, order_errs, stim_errs);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // Hold request until the DUT takes it
  task automatic send_instr(opcode_e op, tag_t dest, tag_t s1, tag_t s2);
    logic rdy;
    in_valid = 1'b1;
    in_op    = op;
    in_dest  = dest;
    in_src1  = s1;
    in_src2  = s2;
    do begin
      @(negedge clock);
      rdy = in_ready;  // Stable between drive and edge
      if (!rdy) saw_stall = 1'b1;
      @(posedge clock);
      #2;
    end while (!rdy);
    in_valid = 1'b0;
  endtask

  task automatic wait_round();
    while (pending != 0) begin
      @(posedge clock);
      #2;
    end
  endtask

  // Fresh distinct dests from 8..31
  task automatic pick_dests(int count);
    tag_t pool [24];
    tag_t tmp;
    int   j;
    for (int i = 0; i < 24; i++) pool[i] = tag_t'(i + 8);
    for (int i = 23; i > 0; i--) begin
      j       = $urandom_range(i, 0);
      tmp     = pool[i];
      pool[i] = pool[j];
      pool[j] = tmp;
    end
    round_dests.delete();
    for (int i = 0; i < count; i++) round_dests.push_back(pool[i]);
  endtask

  function automatic logic in_round(tag_t t);
    foreach (round_dests[i]) begin
      if (round_dests[i] == t) return 1'b1;
    end
    return 1'b0;
  endfunction

  // Earlier dest in the round, or a tag the round never writes
  function automatic tag_t pick_src(int k);
    tag_t t;
    if (k > 0 && $urandom_range(1, 0) == 1) begin
      t = round_dests[$urandom_range(k - 1, 0)];  // Dependency chain
    end else begin
      do begin
        t = tag_t'($urandom_range(NUM_TAGS - 1, 0));
      end while (in_round(t));
    end
    return t;
  endfunction

  task automatic random_round(int count);
    opcode_e op;
    pick_dests(count);
    for (int k = 0; k < count; k++) begin
      op = opcode_e'($urandom_range(4, 0));
      send_instr(op, round_dests[k], pick_src(k), pick_src(k));
    end
    wait_round();
  endtask

  initial begin
    void'($urandom(32'h70082ca7));
    reset     = 1'b1;
    in_valid  = 1'b0;
    in_op     = OP_ADD;
    in_dest   = '0;
    in_src1   = '0;
    in_src2   = '0;
    saw_stall = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #2 reset = 1'b0;
    @(negedge clock);
    if (in_ready !== 1'b1 || cmp_valid !== 1'b0) begin
      $display("FAIL %0t: outputs not idle after reset, in_ready %b, cmp_valid %b",
               $time, in_ready, cmp_valid);
      stim_errs++;
    end
    @(posedge clock);
    #2;
    // Independent ALU ops on reset values
    send_instr(OP_ADD, 8, 1, 2);
    send_instr(OP_SUB, 9, 3, 7);
    send_instr(OP_AND, 10, 6, 5);
    send_instr(OP_XOR, 11, 4, 7);
    send_instr(OP_ADD, 12, 7, 7);
    send_instr(OP_SUB, 13, 0, 5);   // Wraps below zero
    wait_round();
    // ALU, MUL, ALU chain
    send_instr(OP_ADD, 8, 2, 3);
    send_instr(OP_MUL, 9, 8, 5);
    send_instr(OP_SUB, 10, 9, 8);
    send_instr(OP_MUL, 11, 10, 10);
    send_instr(OP_XOR, 12, 11, 9);
    wait_round();
    // MUL burst parked behind one slow producer
    saw_stall = 1'b0;
    send_instr(OP_MUL, 8, 3, 5);
    for (int k = 9; k < 16; k++) send_instr(OP_MUL, tag_t'(k), 8, tag_t'(k - 8));
    wait_round();
    if (!saw_stall) begin
      $display("in_ready never went low during the MUL burst");
      stim_errs++;
    end
    // ALU and MUL results land on the same cycle
    send_instr(OP_MUL, 8, 3, 4);
    send_instr(OP_ADD, 9, 1, 6);
    send_instr(OP_ADD, 10, 2, 5);
    send_instr(OP_XOR, 11, 7, 3);
    send_instr(OP_MUL, 12, 6, 7);
    send_instr(OP_SUB, 13, 2, 6);
    send_instr(OP_AND, 14, 7, 5);
    send_instr(OP_ADD, 15, 4, 4);
    wait_round();
    // Random mix in rounds
    sent = 0;
    while (sent < RANDOM_INSTR) begin
      n = $urandom_range(16, 4);
      if (n > RANDOM_INSTR - sent) n = RANDOM_INSTR - sent;
      random_round(n);
      sent += n;
    end
    repeat (5) @(posedge clock);  // Catch stray completions
    $display("Errors: value %0d, tag %0d, order %0d, stimulus %0d",
             value_errs, tag_errs, order_errs, stim_errs);
    if (value_errs + tag_errs + order_errs + stim_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
rtl/ooo_pkg.sv
rtl/ooo_if.sv
rtl/dispatch_stage.sv
rtl/reservation_station.sv
rtl/phys_regfile.sv
rtl/exec_unit.sv
rtl/cdb_arbiter.sv
rtl/ooo_issue_top.sv
dv/tb_checker.sv
dv/tb_top.sv
